//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f z80_bridge.f --top-module z80_bridge_tb -o z80_bridge_sim

./obj_dir/z80_bridge_sim 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
   echo "Result: PASS"
else
   echo "Result: FAIL"
   exit 1
fi

//--- source/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// ************************************************************
// Memory window
// ************************************************************

// Z80 addr[21:19] of the 512 KB socket window
`define MEMORY_RANGE 3'b010

// Implemented GPU RAM, everything above reads as 0xFF
`define MEM_SIZE_BITS 15

// addr[21:4] of the 16-byte bank ID block at 0x17FFF0
`define BANK_ID_ADDR 18'h17FFF

// ************************************************************
// IO ports
// ************************************************************

`define IO_KBD_PORT 8'hF0   // Keyboard character, cleared on read
`define IO_SPKR_PORT 8'hF2  // Speaker one-shot
`define IO_BLNK_PORT 8'hF3  // Video blank control

// ************************************************************
// Bus timing in GPU_CLK cycles
// ************************************************************

`define WR_QUALIFY_CYCLES 3  // Access must hold this long before the GPU pulse
`define IO_SETTLE_CYCLES 6   // 245 turnaround before driving IO read data

`endif

//--- source/bridge_pkg.sv
package bridge_pkg;

   // ************************************************************
   // GPU side
   // ************************************************************

   typedef struct packed {
      logic [19:0] addr;    // GPU RAM byte address
      logic [7:0]  wdata;   // Write data
      logic        wr_ena;  // One-cycle write strobe
      logic        rd_req;  // One-cycle read request
   } gpu_req_t;

   // Read data offered back towards the Z80 data bus
   typedef struct packed {
      logic       drive;  // Wants the data bus
      logic [7:0] data;
   } rd_resp_t;

   // ************************************************************
   // Decodes and states
   // ************************************************************

   typedef enum logic [1:0] {
      port_none,
      port_kbd,
      port_spkr,
      port_blnk
   } io_port_e;

   typedef enum logic [1:0] {
      src_ram,      // Inside implemented GPU RAM
      src_bank_id,  // Bank ID block
      src_open      // Rest of the window
   } rd_src_e;

   typedef enum logic [1:0] {
      io_idle,
      io_settle,  // Waiting for the level converter to turn around
      io_drive
   } io_state_e;

   // Bank ID answer, indexed by addr[3:0]
   localparam logic [7:0] bank_id_table [16] = '{
      8'd9,  8'd3,  8'd71, 8'd80, 8'd85, 8'd32, 8'd69,  8'd80,
      8'd52, 8'd67, 8'd69, 8'd49, 8'd48, 8'd0,  8'd255, 8'd255
   };

endpackage

//--- source/bus_driver.sv
module bus_driver import bridge_pkg::*; (
   input  logic       GPU_CLK,
   input  logic       rst_n,
   input  rd_resp_t   mem_resp,
   input  rd_resp_t   io_resp,
   output logic [7:0] z80_rdata,
   output logic       z80_rdata_ena,
   output logic       z80_245data_dir
);

   logic       any_drive;
   logic [7:0] merged_data;

   // ************************************************************
   // Response merge, IO first
   // ************************************************************

   assign any_drive = io_resp.drive || mem_resp.drive;

   always_comb begin
      if (io_resp.drive) merged_data = io_resp.data;
      else if (mem_resp.drive) merged_data = mem_resp.data;
      else merged_data = 8'h00;  // Idle bus reads zero
   end

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         z80_rdata       <= 8'h00;
         z80_rdata_ena   <= 1'b0;
         z80_245data_dir <= 1'b0;  // 245 towards the FPGA
      end else begin
         z80_rdata       <= merged_data;
         z80_rdata_ena   <= any_drive;  // Output pins on
         z80_245data_dir <= any_drive;  // 245 towards the Z80
      end
   end

   a_dir_matches_ena : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      z80_245data_dir == z80_rdata_ena)
      else $error("245 direction disagrees with data enable");

endmodule

//--- source/io_ports.sv
`include "bridge_config.svh"

module io_ports import z80_bus_pkg::*, bridge_pkg::*; #(
   parameter logic [7:0] IO_KBD_PORT      = `IO_KBD_PORT,
   parameter logic [7:0] IO_SPKR_PORT     = `IO_SPKR_PORT,
   parameter logic [7:0] IO_BLNK_PORT     = `IO_BLNK_PORT,
   parameter int         IO_SETTLE_CYCLES = `IO_SETTLE_CYCLES
) (
   input  logic       GPU_CLK,
   input  logic       rst_n,
   input  z80_bus_t   bus,
   input  logic       ps2_rdy,
   input  logic [7:0] ps2_dat,
   output rd_resp_t   io_resp,
   output logic       spkr_en,
   output logic       video_en
);

   localparam int CNT_W = $clog2(IO_SETTLE_CYCLES + 1);

   bus_cycle_e cyc;
   io_port_e   port;
   logic       io_active;
   logic       io_prev;
   logic       io_start;     // First cycle of any IO access
   logic       kbd_rd;
   logic       spkr_wr;
   logic       blnk_wr;
   logic       ps2_prev;
   logic [7:0] kbd_char;
   io_state_e  state;
   logic [CNT_W-1:0] settle_cnt;

   // ************************************************************
   // Port decode and cycle start
   // ************************************************************

   always_comb begin
      case (bus.addr[7:0])
         IO_KBD_PORT:  port = port_kbd;
         IO_SPKR_PORT: port = port_spkr;
         IO_BLNK_PORT: port = port_blnk;
         default:      port = port_none;
      endcase
   end

   assign cyc       = classify_cycle(bus);
   assign io_active = (cyc == cyc_io_rd) || (cyc == cyc_io_wr);
   assign io_start  = io_active && !io_prev;
   assign kbd_rd    = (cyc == cyc_io_rd) && (port == port_kbd);
   assign spkr_wr   = (cyc == cyc_io_wr) && (port == port_spkr);
   assign blnk_wr   = (cyc == cyc_io_wr) && (port == port_blnk);

   // ************************************************************
   // Keyboard latch and delayed read
   // ************************************************************

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         io_prev    <= 1'b0;
         ps2_prev   <= 1'b0;
         kbd_char   <= 8'h00;
         state      <= io_idle;
         settle_cnt <= '0;
      end else begin
         io_prev  <= io_active;
         ps2_prev <= ps2_rdy;
         if (ps2_rdy && !ps2_prev) kbd_char <= ps2_dat;  // New key on rising edge
         case (state)
            io_idle: begin
               settle_cnt <= '0;
               if (io_start && kbd_rd) state <= io_settle;
            end
            io_settle: begin
               if (!kbd_rd) begin            // Host gave up early
                  state    <= io_idle;
                  kbd_char <= 8'h00;
               end else if (settle_cnt == CNT_W'(IO_SETTLE_CYCLES - 1)) begin
                  state <= io_drive;
               end else begin
                  settle_cnt <= settle_cnt + 1'b1;
               end
            end
            io_drive: begin
               if (!kbd_rd) begin            // IORQ or RD released
                  state    <= io_idle;
                  kbd_char <= 8'h00;         // Character consumed
               end
            end
            default: state <= io_idle;
         endcase
      end
   end

   assign io_resp = '{drive: (state == io_drive), data: kbd_char};

   // ************************************************************
   // Speaker and video enable
   // ************************************************************

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         spkr_en  <= 1'b0;
         video_en <= 1'b1;  // Video on out of reset
      end else begin
         spkr_en <= io_start && spkr_wr && (bus.wdata != 8'h00);  // One-shot
         if (io_start && blnk_wr) video_en <= (bus.wdata != 8'h00);
      end
   end

   a_spkr_one_shot : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      spkr_en |=> !spkr_en)
      else $error("spkr_en held for more than one cycle");

endmodule

//--- source/mem_access.sv
`include "bridge_config.svh"

module mem_access import z80_bus_pkg::*, bridge_pkg::*; #(
   parameter logic [2:0]  MEMORY_RANGE      = `MEMORY_RANGE,
   parameter int          MEM_SIZE_BITS     = `MEM_SIZE_BITS,
   parameter logic [17:0] BANK_ID_ADDR      = `BANK_ID_ADDR,
   parameter int          WR_QUALIFY_CYCLES = `WR_QUALIFY_CYCLES
) (
   input  logic       GPU_CLK,
   input  logic       rst_n,
   input  z80_bus_t   bus,
   input  logic [7:0] gpu_rdata,
   input  logic       gpu_rd_rdy,
   output gpu_req_t   gpu,
   output rd_resp_t   mem_resp
);

   logic       mem_window;      // addr in the socket window
   logic       mem_valid_range; // addr inside implemented RAM
   logic       bank_id_access;  // addr in the bank ID block
   bus_cycle_e cyc;
   logic [1:0] qual;            // [1] write, [0] read
   logic [WR_QUALIFY_CYCLES-1:0][1:0] qual_hist;
   logic [1:0] held;
   logic [1:0] fire;
   logic       wr_pulse;
   logic       rd_pulse;
   logic [19:0] gpu_addr;
   logic [7:0] gpu_wdata;
   rd_src_e    rd_src;
   logic [7:0] rd_byte;
   logic       resp_drive;
   logic [7:0] resp_data;

   // ************************************************************
   // Decode and qualify
   // ************************************************************

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         mem_window      <= 1'b0;
         mem_valid_range <= 1'b0;
         bank_id_access  <= 1'b0;
      end else begin
         mem_window      <= (bus.addr[21:19] == MEMORY_RANGE);
         mem_valid_range <= ({1'b0, bus.addr[18:0]} < 20'(2 ** MEM_SIZE_BITS));
         bank_id_access  <= (bus.addr[21:4] == BANK_ID_ADDR);
      end
   end

   assign cyc     = classify_cycle(bus);
   assign qual[1] = mem_window && mem_valid_range && (cyc == cyc_mem_wr); // RAM range only
   assign qual[0] = mem_window && (cyc == cyc_mem_rd);                    // Whole window

   // Held for WR_QUALIFY_CYCLES in a row and not one more
   always_comb begin
      held = qual;
      for (int i = 0; i < WR_QUALIFY_CYCLES - 1; i++) begin
         held = held & qual_hist[i];
      end
      fire = held & ~qual_hist[WR_QUALIFY_CYCLES-1];
   end

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         qual_hist <= '0;
         wr_pulse  <= 1'b0;
         rd_pulse  <= 1'b0;
      end else begin
         qual_hist <= {qual_hist[WR_QUALIFY_CYCLES-2:0], qual}; // Oldest at the top
         wr_pulse  <= fire[1];
         rd_pulse  <= fire[0];
      end
   end

   always_ff @(posedge GPU_CLK) begin
      gpu_addr <= {1'b0, bus.addr[18:0]};   // Follows the held address
      if (qual[1]) gpu_wdata <= bus.wdata;  // Capture while the write is live
   end

   assign gpu = '{addr: gpu_addr, wdata: gpu_wdata, wr_ena: wr_pulse, rd_req: rd_pulse};

   // ************************************************************
   // Read byte select
   // ************************************************************

   assign rd_src = mem_valid_range ? src_ram : (bank_id_access ? src_bank_id : src_open);

   always_comb begin
      case (rd_src)
         src_ram:     rd_byte = gpu_rdata;
         src_bank_id: rd_byte = bank_id_table[bus.addr[3:0]];
         default:     rd_byte = 8'hFF;  // Unpopulated part of the window
      endcase
   end

   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) resp_drive <= 1'b0;
      else resp_drive <= qual[0];       // One cycle behind the read qualifier
   end

   always_ff @(posedge GPU_CLK) begin
      if (gpu_rd_rdy) resp_data <= rd_byte;
   end

   assign mem_resp = '{drive: resp_drive, data: resp_data};

   a_wr_rd_excl : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      !(gpu.wr_ena && gpu.rd_req))
      else $error("GPU write and read request in the same cycle");

endmodule

//--- source/z80_bridge.sv
module z80_bridge import z80_bus_pkg::*, bridge_pkg::*; (
   input  logic       GPU_CLK,
   input  logic       rst_n,
   input  z80_bus_t   bus,
   input  logic [7:0] gpu_rdata,
   input  logic       gpu_rd_rdy,
   input  logic       ps2_rdy,
   input  logic [7:0] ps2_dat,
   output gpu_req_t   gpu,
   output logic [7:0] z80_rdata,
   output logic       z80_rdata_ena,
   output logic       z80_245data_dir,
   output logic       spkr_en,
   output logic       video_en
);

   rd_resp_t mem_resp;  // Memory read data
   rd_resp_t io_resp;   // Keyboard read data

   mem_access u_mem_access (
      .GPU_CLK    (GPU_CLK),
      .rst_n      (rst_n),
      .bus        (bus),
      .gpu_rdata  (gpu_rdata),
      .gpu_rd_rdy (gpu_rd_rdy),
      .gpu        (gpu),
      .mem_resp   (mem_resp)
   );

   io_ports u_io_ports (
      .GPU_CLK  (GPU_CLK),
      .rst_n    (rst_n),
      .bus      (bus),
      .ps2_rdy  (ps2_rdy),
      .ps2_dat  (ps2_dat),
      .io_resp  (io_resp),
      .spkr_en  (spkr_en),
      .video_en (video_en)
   );

   bus_driver u_bus_driver (
      .GPU_CLK         (GPU_CLK),
      .rst_n           (rst_n),
      .mem_resp        (mem_resp),
      .io_resp         (io_resp),
      .z80_rdata       (z80_rdata),
      .z80_rdata_ena   (z80_rdata_ena),
      .z80_245data_dir (z80_245data_dir)
   );

endmodule

//--- source/z80_bus_pkg.sv
package z80_bus_pkg;

   // Raw Z80 bus inputs as seen by the FPGA
   typedef struct packed {
      logic        m1_n;    // Opcode fetch, low during M1
      logic        mreq_n;  // Memory request
      logic        iorq_n;  // IO request
      logic        rd_n;    // Read strobe
      logic        wr_n;    // Write strobe
      logic [21:0] addr;    // Extended address bus
      logic [7:0]  wdata;   // Data from the host
   } z80_bus_t;

   typedef enum logic [2:0] {
      cyc_idle,
      cyc_mem_rd,
      cyc_mem_wr,
      cyc_io_rd,
      cyc_io_wr
   } bus_cycle_e;

   // Decode the live strobes into one cycle kind, writes win a strobe clash
   function automatic bus_cycle_e classify_cycle(input z80_bus_t bus);
      bus_cycle_e cyc;
      cyc = cyc_idle;
      if (!bus.mreq_n && bus.m1_n) begin
         if (!bus.wr_n) cyc = cyc_mem_wr;
         else if (!bus.rd_n) cyc = cyc_mem_rd;
      end else if (!bus.iorq_n && bus.m1_n) begin  // M1 with IORQ is an INTA, not IO
         if (!bus.wr_n) cyc = cyc_io_wr;
         else if (!bus.rd_n) cyc = cyc_io_rd;
      end
      return cyc;
   endfunction

endpackage

//--- test/z80_bridge_tb.sv
`include "bridge_config.svh"

module z80_bridge_tb import z80_bus_pkg::*, bridge_pkg::*; ();

   localparam int NUM_ROWS       = 24;
   localparam int HOLD_CYCLES    = 12;                    // Bus held per row
   localparam int IDLE_CYCLES    = 4;                     // Idle gap after each row
   localparam int TIMEOUT_CYCLES = NUM_ROWS * 16 + 100;
   localparam int RAM_BYTES      = 1 << `MEM_SIZE_BITS;
   localparam logic [31:0] SEED  = 32'd90718;

   typedef enum logic [2:0] {rk_mem_rd, rk_mem_wr, rk_io_rd, rk_io_wr, rk_key} row_kind_e;

   typedef struct packed {
      row_kind_e   kind;
      logic [21:0] addr;
      logic [7:0]  data;      // Write data or key character
      logic [7:0]  exp_byte;  // Expected z80_rdata for reads
   } row_t;

   logic       GPU_CLK = 1'b0;
   logic       rst_n;
   z80_bus_t   bus;
   logic [7:0] gpu_rdata;
   logic       gpu_rd_rdy;
   logic       ps2_rdy;
   logic [7:0] ps2_dat;
   gpu_req_t   gpu;
   logic [7:0] z80_rdata;
   logic       z80_rdata_ena;
   logic       z80_245data_dir;
   logic       spkr_en;
   logic       video_en;

   row_t       rows [NUM_ROWS];
   logic [7:0] ram_model [RAM_BYTES];  // GPU RAM contents
   logic [7:0] shadow [RAM_BYTES];     // Expected RAM contents
   int         value_errors = 0;
   int         pulse_errors = 0;
   int         wr_pulses = 0;
   int         rd_pulses = 0;
   int         spkr_pulses = 0;
   int         cycle_count = 0;
   gpu_req_t   last_wr;                // GPU request seen at the last write pulse
   logic       exp_video;

   z80_bridge u_z80_bridge (
      .GPU_CLK         (GPU_CLK),
      .rst_n           (rst_n),
      .bus             (bus),
      .gpu_rdata       (gpu_rdata),
      .gpu_rd_rdy      (gpu_rd_rdy),
      .ps2_rdy         (ps2_rdy),
      .ps2_dat         (ps2_dat),
      .gpu             (gpu),
      .z80_rdata       (z80_rdata),
      .z80_rdata_ena   (z80_rdata_ena),
      .z80_245data_dir (z80_245data_dir),
      .spkr_en         (spkr_en),
      .video_en        (video_en)
   );

   always #20 GPU_CLK = ~GPU_CLK;  // 40 unit period

   // ************************************************************
   // Helpers
   // ************************************************************

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic in_window(input logic [21:0] addr);
      return addr[21:19] == `MEMORY_RANGE;
   endfunction

   function automatic logic in_range(input logic [21:0] addr);
      return in_window(addr) && (addr[18:`MEM_SIZE_BITS] == '0);  // Below 32 KB
   endfunction

   function automatic z80_bus_t idle_bus();
      z80_bus_t b;
      b = '{m1_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1,
            addr: '0, wdata: '0};
      return b;
   endfunction

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
      end
   endtask

   task automatic check_gpu_req(input gpu_req_t got, input gpu_req_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: GPU write addr 0x%05h data 0x%02h, expected 0x%05h 0x%02h",
                  $time, got.addr, got.wdata, exp.addr, exp.wdata);
      end
   endtask

   task automatic check_pulses(input string what, input int got, input int exp);
      if (got != exp) begin
         pulse_errors++;
         $display("** Error at %0t: %0d %s pulses, expected %0d", $time, got, what, exp);
      end
   endtask

   // ************************************************************
   // GPU RAM model, pulse monitor and timeout
   // ************************************************************

   initial begin
      logic [31:0] state;
      logic [1:0]  rd_pipe;
      logic [`MEM_SIZE_BITS-1:0] addr_pipe [2];
      state = SEED;
      for (int a = 0; a < RAM_BYTES; a++) begin
         state = lcg_next(state);
         ram_model[a] = state[23:16];
      end
      gpu_rd_rdy = 1'b0;
      gpu_rdata  = 8'h00;
      rd_pipe    = 2'b00;
      forever begin
         @(posedge GPU_CLK);
         #2;
         if (gpu.wr_ena) ram_model[gpu.addr[`MEM_SIZE_BITS-1:0]] = gpu.wdata;
         rd_pipe      = {rd_pipe[0], gpu.rd_req};             // Answer two cycles on
         addr_pipe[1] = addr_pipe[0];
         addr_pipe[0] = gpu.addr[`MEM_SIZE_BITS-1:0];
         gpu_rd_rdy   = rd_pipe[1];
         gpu_rdata    = rd_pipe[1] ? ram_model[addr_pipe[1]] : 8'h00;
      end
   end

   always @(negedge GPU_CLK) begin
      if (rst_n) begin
         if (gpu.wr_ena) begin
            wr_pulses++;
            last_wr = gpu;
         end
         if (gpu.rd_req) rd_pulses++;
         if (spkr_en) spkr_pulses++;
      end
   end

   always @(posedge GPU_CLK) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // ************************************************************
   // Stimulus table
   // ************************************************************

   task automatic build_table();
      rows[0]  = '{rk_mem_wr, 22'h100123, 8'hA5, 8'h00};  // In range
      rows[1]  = '{rk_mem_rd, 22'h100123, 8'h00, 8'h00};  // Reads back the write
      rows[2]  = '{rk_mem_rd, 22'h104567, 8'h00, 8'h00};
      rows[3]  = '{rk_mem_wr, 22'h107FFF, 8'h3C, 8'h00};  // Top RAM byte
      rows[4]  = '{rk_mem_rd, 22'h107FFF, 8'h00, 8'h00};
      rows[5]  = '{rk_mem_wr, 22'h108000, 8'h77, 8'h00};  // Above range so dropped
      rows[6]  = '{rk_mem_rd, 22'h100000, 8'h00, 8'h00};  // Would alias 0x108000
      rows[7]  = '{rk_mem_wr, 22'h000123, 8'h55, 8'h00};  // Outside window
      rows[8]  = '{rk_mem_rd, 22'h17FFF0, 8'h00, 8'd9};   // Bank ID block
      rows[9]  = '{rk_mem_rd, 22'h17FFF2, 8'h00, 8'd71};
      rows[10] = '{rk_mem_rd, 22'h17FFFE, 8'h00, 8'd255};
      rows[11] = '{rk_mem_rd, 22'h17FFF7, 8'h00, 8'd80};
      rows[12] = '{rk_mem_rd, 22'h120000, 8'h00, 8'hFF};  // Open window
      rows[13] = '{rk_mem_rd, 22'h17FFEF, 8'h00, 8'hFF};  // Just below bank ID
      rows[14] = '{rk_mem_rd, 22'h200123, 8'h00, 8'h00};  // Outside window
      rows[15] = '{rk_key,    22'h000000, 8'h41, 8'h00};
      rows[16] = '{rk_io_rd,  22'h0000F0, 8'h00, 8'h41};
      rows[17] = '{rk_io_rd,  22'h0000F0, 8'h00, 8'h00};  // Latch cleared
      rows[18] = '{rk_io_wr,  22'h0000F2, 8'h05, 8'h00};
      rows[19] = '{rk_io_wr,  22'h0000F2, 8'h00, 8'h00};  // Silent
      rows[20] = '{rk_io_wr,  22'h0000F3, 8'h00, 8'h00};  // Blank video
      rows[21] = '{rk_io_wr,  22'h0000F3, 8'h80, 8'h00};
      rows[22] = '{rk_key,    22'h000000, 8'h5A, 8'h00};
      rows[23] = '{rk_io_rd,  22'h0000F0, 8'h00, 8'h5A};
   endtask

   // RAM read rows take their byte from the preload and earlier writes
   task automatic fill_expected();
      logic [31:0] state;
      state = SEED;
      for (int a = 0; a < RAM_BYTES; a++) begin
         state = lcg_next(state);
         shadow[a] = state[23:16];
      end
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (rows[i].kind == rk_mem_wr && in_range(rows[i].addr))
            shadow[rows[i].addr[`MEM_SIZE_BITS-1:0]] = rows[i].data;
         if (rows[i].kind == rk_mem_rd && in_range(rows[i].addr))
            rows[i].exp_byte = shadow[rows[i].addr[`MEM_SIZE_BITS-1:0]];
      end
   endtask

   task automatic apply_row(input row_t r);
      int       wr_base;
      int       rd_base;
      int       spkr_base;
      logic     exp_ena;
      gpu_req_t exp_req;
      wr_base   = wr_pulses;
      rd_base   = rd_pulses;
      spkr_base = spkr_pulses;
      bus       = idle_bus();
      bus.addr  = r.addr;
      bus.wdata = r.data;
      case (r.kind)
         rk_mem_rd: {bus.mreq_n, bus.rd_n} = 2'b00;
         rk_mem_wr: {bus.mreq_n, bus.wr_n} = 2'b00;
         rk_io_rd:  {bus.iorq_n, bus.rd_n} = 2'b00;
         rk_io_wr:  {bus.iorq_n, bus.wr_n} = 2'b00;
         default: begin
            ps2_dat = r.data;  // Key strobe only with the bus idle
            ps2_rdy = 1'b1;
         end
      endcase
      for (int i = 0; i < HOLD_CYCLES; i++) begin
         @(posedge GPU_CLK);
         #2;
         if (i == 1) ps2_rdy = 1'b0;
      end
      exp_ena = (r.kind == rk_mem_rd && in_window(r.addr)) ||
                (r.kind == rk_io_rd && r.addr[7:0] == `IO_KBD_PORT);
      if (r.kind == rk_io_wr && r.addr[7:0] == `IO_BLNK_PORT) exp_video = (r.data != 8'h00);
      check_flag("z80_rdata_ena", z80_rdata_ena, exp_ena);
      check_flag("z80_245data_dir", z80_245data_dir, exp_ena);
      check_byte("z80_rdata", z80_rdata, r.exp_byte);  // Zero whenever nothing drives
      check_flag("video_en", video_en, exp_video);
      bus = idle_bus();
      repeat (IDLE_CYCLES) begin
         @(posedge GPU_CLK);
         #2;
      end
      check_pulses("wr_ena", wr_pulses - wr_base,
                   (r.kind == rk_mem_wr && in_range(r.addr)) ? 1 : 0);
      check_pulses("rd_req", rd_pulses - rd_base,
                   (r.kind == rk_mem_rd && in_window(r.addr)) ? 1 : 0);
      check_pulses("spkr_en", spkr_pulses - spkr_base,
                   (r.kind == rk_io_wr && r.addr[7:0] == `IO_SPKR_PORT && r.data != 8'h00) ? 1 : 0);
      if (r.kind == rk_mem_wr && in_range(r.addr) && wr_pulses != wr_base) begin
         exp_req = '{addr: 20'(r.addr[`MEM_SIZE_BITS-1:0]), wdata: r.data,
                     wr_ena: 1'b1, rd_req: 1'b0};  // RAM byte index
         check_gpu_req(last_wr, exp_req);
      end
   endtask

   initial begin
      bus     = idle_bus();
      ps2_rdy = 1'b0;
      ps2_dat = 8'h00;
      rst_n   = 1'b0;
      build_table();
      fill_expected();
      repeat (10) @(posedge GPU_CLK);
      #2;
      rst_n = 1'b1;
      @(posedge GPU_CLK);
      #2;
      exp_video = 1'b1;  // Video on out of reset
      check_flag("video_en after reset", video_en, exp_video);
      check_flag("z80_rdata_ena after reset", z80_rdata_ena, 1'b0);
      for (int i = 0; i < NUM_ROWS; i++) apply_row(rows[i]);
      $display("Errors: %0d value, %0d pulse, %0d total",
               value_errors, pulse_errors, value_errors + pulse_errors);
      if (value_errors + pulse_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- z80_bridge.f
+incdir+source
source/z80_bus_pkg.sv
source/bridge_pkg.sv
source/mem_access.sv
source/io_ports.sv
source/bus_driver.sv
source/z80_bridge.sv
test/z80_bridge_tb.sv
